//--- compile.f
+incdir+verif
hw/evb_pkg.sv
hw/point_coef_buffer.sv
hw/horner_evaluator.sv
hw/evb_sequencer.sv
hw/evb_top.sv
verif/evb_tb.sv

//--- verif/evb_model.svh
// Batch evaluation reference model
`ifndef EVB_MODEL_SVH
`define EVB_MODEL_SVH

logic [31:0] lfsr_state = 32'd86948;
data_t       pt_model [buffer_size];
data_t       coef_model [COEF_DEPTH];

// Fibonacci LFSR with taps 32 22 2 1
function automatic logic lfsr_bit();
	logic fb;
	fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
	lfsr_state = {lfsr_state[30:0], fb};
	return fb;
endfunction

function automatic logic [31:0] rand_bits(input int width);
	logic [31:0] v;
	int          i;
	v = '0;
	for (i = 0; i < width; i++)
		v = {v[30:0], lfsr_bit()};   // One step per bit
	return v;
endfunction

function automatic batch_t rand_count();
	batch_t v;
	v = batch_t'(rand_bits(5));
	if (v == '0)
		v = batch_t'(1);             // Batch of 1 to 31
	return v;
endfunction

// Horner's rule, highest coefficient first, wraps mod 2^32
function automatic acc_t horner_model(input data_t x, input poly_sel_t a, input degree_t n);
	acc_t acc;
	int   i;
	acc = '0;
	for (i = int'(n); i >= 0; i--)
		acc = acc * acc_t'(x) + acc_t'(coef_model[int'(a) * POLY_COEFS + i]);
	return acc;
endfunction

function automatic void push_expected(input acc_t v);
	exp_mem[wr_ptr] = v;
	wr_ptr = wr_ptr + 1;
endfunction

`endif

//--- verif/evb_tb.sv
// Batch evaluation testbench
`timescale 1ns/1ps
`default_nettype none

module evb_tb
	import evb_pkg::*;
();

	localparam int buffer_size = 1024;
	localparam int pt_aw = $clog2(buffer_size);
	localparam int wr_aw = (pt_aw > $bits(coef_addr_t)) ? pt_aw : $bits(coef_addr_t);

	logic             clk = 1'b0;
	logic             rst;
	logic             rst_instr;
	logic             start_evb;
	logic [pt_aw-1:0] point_base;
	batch_t           b;
	poly_sel_t        A;
	degree_t          N;
	logic             wr_en;
	logic             wr_sel;
	logic [wr_aw-1:0] wr_addr;
	data_t            wr_data;
	logic             busy;
	acc_t             result;
	logic             result_valid;
	logic             done_evb;

	acc_t exp_mem [2048];    // Expected results in strobe order
	int   wr_ptr = 0;
	int   rd_ptr;
	int   gap;               // Cycles since last accepted start or strobe
	int   job_n = 0;
	logic started;
	logic cleared;
	int   cycle_cnt = 0;
	int   cycle_limit = 0;

	`include "evb_model.svh"

	evb_top #(.buffer_size(buffer_size)) u_dut (
		.clk          (clk),
		.rst          (rst),
		.rst_instr    (rst_instr),
		.start_evb    (start_evb),
		.point_base   (point_base),
		.b            (b),
		.A            (A),
		.N            (N),
		.wr_en        (wr_en),
		.wr_sel       (wr_sel),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.busy         (busy),
		.result       (result),
		.result_valid (result_valid),
		.done_evb     (done_evb)
	);

	always #20 clk = ~clk;

	task automatic report_fail(input string msg);
		$display("FAIL %0t ns: %s", $time, msg);
		$display("Test FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	// ********************
	// Scoreboard
	// ********************

	always @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			rd_ptr  <= 0;
			gap     <= 0;
			started <= 1'b0;
			cleared <= 1'b0;
		end
		else
		begin
			if (!rst_instr)
				rd_ptr <= wr_ptr;              // Drop the abandoned results
			else if (result_valid)
				rd_ptr <= rd_ptr + 1;
			if ((start_evb && !busy) || result_valid)
				gap <= 1;
			else
				gap <= gap + 1;
			if (start_evb)
				started <= 1'b1;
			if (!rst_instr)
				cleared <= 1'b1;
			else if (start_evb && !busy)
				cleared <= 1'b0;
		end
	end

	rv_expected: assert property (@(posedge clk) disable iff (!rst)
		result_valid |-> rd_ptr < wr_ptr)
		else report_fail("result strobe with no result outstanding");
	rv_value: assert property (@(posedge clk) disable iff (!rst)
		result_valid && rd_ptr < wr_ptr |-> result == exp_mem[rd_ptr])
		else report_fail("result does not match the model");
	rv_latency: assert property (@(posedge clk) disable iff (!rst)
		result_valid |-> gap == job_n + 4)     // start_evp one cycle later and N+3 after that
		else report_fail("result strobe at the wrong cycle");
	rv_deg0: assert property (@(posedge clk) disable iff (!rst)
		result_valid && job_n == 0 |-> result[31:16] == 16'h0)
		else report_fail("degree 0 result not zero extended");
	rv_pulse: assert property (@(posedge clk) disable iff (!rst)
		result_valid |=> !result_valid)
		else report_fail("result_valid longer than one cycle");
	done_count: assert property (@(posedge clk) disable iff (!rst)
		done_evb |-> rd_ptr == wr_ptr && $past(result_valid))
		else report_fail("done_evb with a wrong result count or timing");
	done_follow: assert property (@(posedge clk) disable iff (!rst)
		result_valid && rst_instr && rd_ptr + 1 == wr_ptr |=> done_evb)
		else report_fail("done_evb missing after the last result");
	done_pulse: assert property (@(posedge clk) disable iff (!rst)
		done_evb |=> !done_evb && !busy)
		else report_fail("done_evb too long or busy stuck high");
	busy_rise: assert property (@(posedge clk) disable iff (!rst)
		start_evb && !busy && rst_instr |=> busy)
		else report_fail("busy did not rise after a start");
	clear_quiet: assert property (@(posedge clk) disable iff (!rst)
		cleared |-> !busy && !result_valid && !done_evb && result == '0)
		else report_fail("activity after the synchronous clear");
	reset_quiet: assert property (@(posedge clk) disable iff (!rst)
		!started |-> !busy && !result_valid && !done_evb && result == '0)
		else report_fail("activity after reset before any start");

	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > cycle_limit)
		begin
			$display("Timeout: the run did not end within %0d cycles", cycle_limit);
			$display("Test FAILED");
			$fatal(1, "timeout");
		end
	end

	// ********************
	// Stimulus
	// ********************

	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	task automatic load_memories();
		int i;
		wr_en = 1'b1;
		for (i = 0; i < buffer_size + COEF_DEPTH; i++)
		begin
			wr_sel  = (i >= buffer_size);
			wr_addr = wr_aw'(wr_sel ? i - buffer_size : i);
			wr_data = data_t'(rand_bits(16));
			if (wr_sel)
				coef_model[i - buffer_size] = wr_data;
			else
				pt_model[i] = wr_data;
			tick();
		end
		wr_en = 1'b0;
	endtask

	task automatic start_batch(input int base, input batch_t nb, input poly_sel_t a,
		input degree_t n);
		int k;
		for (k = 0; k < int'(nb); k++)
			push_expected(horner_model(pt_model[(base + k) % buffer_size], a, n));
		cycle_limit = cycle_limit + int'(nb) * (int'(n) + 5) + 20;
		job_n       = int'(n);
		point_base  = pt_aw'(base);
		b           = nb;
		A           = a;
		N           = n;
		start_evb   = 1'b1;
		tick();
		start_evb   = 1'b0;
	endtask

	// Extra start pulses at dup_at and dup_at+3 land while busy
	task automatic wait_batch_end(input int dup_at);
		int i;
		i = 0;
		while (!done_evb)
		begin
			start_evb = (dup_at >= 0) && (i == dup_at || i == dup_at + 3);
			if (start_evb)
			begin
				point_base = pt_aw'(rand_bits(pt_aw));
				b          = rand_count();
				A          = poly_sel_t'(rand_bits(3));
				N          = degree_t'(rand_bits(4));
			end
			tick();
			i++;
		end
		start_evb = 1'b0;
		tick();
	endtask

	task automatic clear_mid_batch();
		int      seen;
		degree_t n;
		seen = 0;
		n    = degree_t'(rand_bits(4));
		start_batch(int'(rand_bits(pt_aw)), batch_t'(6), poly_sel_t'(rand_bits(3)), n);
		while (seen < 2)
		begin
			if (result_valid)
				seen++;
			tick();
		end
		rst_instr   = 1'b0;
		tick();
		rst_instr   = 1'b1;
		cycle_limit = cycle_limit + 3 * (int'(n) + 4) + 20;
		repeat (3 * (int'(n) + 4))
			tick();
	endtask

	initial
	begin
		int t;
		rst         = 1'b0;
		rst_instr   = 1'b1;
		start_evb   = 1'b0;
		point_base  = '0;
		b           = batch_t'(1);
		A           = '0;
		N           = '0;
		wr_en       = 1'b0;
		wr_sel      = 1'b0;
		wr_addr     = '0;
		wr_data     = '0;
		cycle_limit = 8 + buffer_size + COEF_DEPTH + 100;
		repeat (8)
			@(posedge clk);
		#2;
		rst = 1'b1;
		load_memories();
		for (t = 0; t < 4; t++)           // Single point batches
		begin
			start_batch(int'(rand_bits(pt_aw)), batch_t'(1), poly_sel_t'(rand_bits(3)),
				degree_t'(rand_bits(4)));
			wait_batch_end(-1);
		end
		for (t = 0; t < 6; t++)
		begin
			start_batch(int'(rand_bits(pt_aw)), rand_count(), poly_sel_t'(rand_bits(3)),
				degree_t'(rand_bits(4)));
			wait_batch_end(-1);
		end
		for (t = 0; t < 8; t++)           // Degree 0 in every slot
		begin
			start_batch(int'(rand_bits(pt_aw)), rand_count(), poly_sel_t'(t), degree_t'(0));
			wait_batch_end(-1);
		end
		start_batch(int'(rand_bits(pt_aw)), rand_count(), poly_sel_t'(rand_bits(3)),
			degree_t'(rand_bits(4)));
		wait_batch_end(2);
		clear_mid_batch();
		start_batch(int'(rand_bits(pt_aw)), rand_count(), poly_sel_t'(rand_bits(3)),
			degree_t'(rand_bits(4)));
		wait_batch_end(-1);
		if (rd_ptr != wr_ptr)
			report_fail("results still outstanding at the end");
		else
		begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- hw/evb_top.sv
// Batch polynomial evaluation engine
`timescale 1ns/1ps
`default_nettype none

module evb_top
	import evb_pkg::*;
#(
	parameter int buffer_size = 1024,
	localparam int pt_aw = $clog2(buffer_size),
	localparam int wr_aw = (pt_aw > $bits(coef_addr_t)) ? pt_aw : $bits(coef_addr_t)
)
(
	input  wire              clk,
	input  wire              rst,
	input  wire              rst_instr,     // Synchronous clear, active low
	input  wire              start_evb,
	input  wire  [pt_aw-1:0] point_base,
	input  wire  batch_t     b,
	input  wire  poly_sel_t  A,
	input  wire  degree_t    N,
	input  wire              wr_en,
	input  wire              wr_sel,        // 0 point memory, 1 coefficient table
	input  wire  [wr_aw-1:0] wr_addr,
	input  wire  data_t      wr_data,
	output logic             busy,
	output acc_t             result,
	output logic             result_valid,
	output logic             done_evb
);

	// ********************
	// Internal nets
	// ********************

	logic             start_evp;
	logic             done_evp;
	logic [pt_aw-1:0] point_addr;
	poly_sel_t        A_job;
	degree_t          N_job;
	logic             pt_rd_en;
	logic [pt_aw-1:0] pt_rd_addr;
	data_t            pt_rd_data;
	logic             coef_rd_en;
	coef_addr_t       coef_rd_addr;
	data_t            coef_rd_data;

	evb_sequencer #(.buffer_size(buffer_size)) u_seq (
		.clk        (clk),
		.rst        (rst),
		.rst_instr  (rst_instr),
		.start_evb  (start_evb),
		.point_base (point_base),
		.b          (b),
		.A          (A),
		.N          (N),
		.done_evp   (done_evp),
		.start_evp  (start_evp),
		.point_addr (point_addr),
		.A_job      (A_job),
		.N_job      (N_job),
		.busy       (busy),
		.done_evb   (done_evb)
	);

	point_coef_buffer #(.buffer_size(buffer_size)) u_buf (
		.clk          (clk),
		.rst          (rst),
		.wr_en        (wr_en),
		.wr_sel       (wr_sel),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.pt_rd_en     (pt_rd_en),
		.pt_rd_addr   (pt_rd_addr),
		.coef_rd_en   (coef_rd_en),
		.coef_rd_addr (coef_rd_addr),
		.pt_rd_data   (pt_rd_data),
		.coef_rd_data (coef_rd_data)
	);

	horner_evaluator #(.buffer_size(buffer_size)) u_eval (
		.clk          (clk),
		.rst          (rst),
		.rst_instr    (rst_instr),
		.start_evp    (start_evp),
		.point_addr   (point_addr),
		.A            (A_job),
		.N            (N_job),
		.pt_rd_data   (pt_rd_data),
		.coef_rd_data (coef_rd_data),
		.pt_rd_en     (pt_rd_en),
		.pt_rd_addr   (pt_rd_addr),
		.coef_rd_en   (coef_rd_en),
		.coef_rd_addr (coef_rd_addr),
		.done_evp     (done_evp),
		.result       (result),
		.result_valid (result_valid)
	);

endmodule

`default_nettype wire

//--- hw/evb_sequencer.sv
// Batch evaluation sequencer
`timescale 1ns/1ps
`default_nettype none

module evb_sequencer
	import evb_pkg::*;
#(
	parameter int buffer_size = 1024,
	localparam int pt_aw = $clog2(buffer_size)
)
(
	input  wire              clk,
	input  wire              rst,
	input  wire              rst_instr,     // Synchronous clear, active low
	input  wire              start_evb,
	input  wire  [pt_aw-1:0] point_base,
	input  wire  batch_t     b,
	input  wire  poly_sel_t  A,
	input  wire  degree_t    N,
	input  wire              done_evp,
	output logic             start_evp,
	output logic [pt_aw-1:0] point_addr,
	output poly_sel_t        A_job,
	output degree_t          N_job,
	output logic             busy,
	output logic             done_evb
);

	typedef enum logic [2:0] {
		s_idle,
		s_launch,
		s_wait,
		s_advance,
		s_end
	} seq_state_t;

	seq_state_t       state, state_nxt;
	batch_t           cnt;         // Index of the point in flight
	logic             accept;
	logic             last_pt;
	logic [pt_aw-1:0] base_q;
	batch_t           b_q;
	poly_sel_t        a_q;
	degree_t          n_q;

	// Start pulses while busy are dropped
	assign accept  = (state == s_idle) && start_evb;
	assign last_pt = (cnt == batch_t'(b_q - 1'b1));

	// ********************
	// Batch state machine
	// ********************

	always_comb
	begin
		state_nxt = state;
		case (state)
			s_idle:
				if (start_evb)
					state_nxt = s_launch;
			s_launch:
				state_nxt = s_wait;
			s_wait:
				if (done_evp)
					state_nxt = last_pt ? s_end : s_advance;
			s_advance:
				state_nxt = s_wait;              // Next point launched here
			s_end:
				state_nxt = s_idle;
			default:
				state_nxt = s_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= s_idle;
			cnt   <= '0;
		end
		else if (!rst_instr)
		begin
			state <= s_idle;                     // Abandon the batch
			cnt   <= '0;
		end
		else
		begin
			state <= state_nxt;
			if (accept)
				cnt <= '0;
			else if (state == s_wait && done_evp && !last_pt)
				cnt <= cnt + 1'b1;
		end
	end

	// Batch settings, held for the whole batch
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			base_q <= point_base;
			b_q    <= b;
			a_q    <= A;
			n_q    <= N;
		end
	end

	// ********************
	// Outputs
	// ********************

	assign start_evp  = (state == s_launch) || (state == s_advance);
	assign point_addr = base_q + pt_aw'(cnt);
	assign A_job      = a_q;
	assign N_job      = n_q;
	assign busy       = (state != s_idle);
	assign done_evb   = (state == s_end);

endmodule

`default_nettype wire

//--- hw/horner_evaluator.sv
// Horner polynomial evaluator
`timescale 1ns/1ps
`default_nettype none

module horner_evaluator
	import evb_pkg::*;
#(
	parameter int buffer_size = 1024,
	localparam int pt_aw = $clog2(buffer_size)
)
(
	input  wire              clk,
	input  wire              rst,
	input  wire              rst_instr,     // Synchronous clear, active low
	input  wire              start_evp,
	input  wire  [pt_aw-1:0] point_addr,
	input  wire  poly_sel_t  A,
	input  wire  degree_t    N,
	input  wire  data_t      pt_rd_data,
	input  wire  data_t      coef_rd_data,
	output logic             pt_rd_en,
	output logic [pt_aw-1:0] pt_rd_addr,
	output logic             coef_rd_en,
	output coef_addr_t       coef_rd_addr,
	output logic             done_evp,
	output acc_t             result,
	output logic             result_valid
);

	localparam coef_addr_t slot_size = coef_addr_t'(POLY_COEFS);

	typedef enum logic [1:0] {
		s_idle,
		s_fetch_pt,
		s_stream,
		s_finish
	} ev_state_t;

	ev_state_t state, state_nxt;
	degree_t   idx;          // Coefficient index, counts N down to 0
	logic      pt_vld;       // Point read data valid this cycle
	logic      coef_vld;     // Coefficient read data valid this cycle
	data_t     x_q;
	acc_t      acc;
	acc_t      fold;
	acc_t      result_q;

	// ********************
	// Control
	// ********************

	always_comb
	begin
		state_nxt = state;
		case (state)
			s_idle:
				if (start_evp)
					state_nxt = s_fetch_pt;
			s_fetch_pt:
				state_nxt = s_stream;
			s_stream:
				if (idx == '0)
					state_nxt = s_finish;        // Last read is coefficient 0
			s_finish:
				state_nxt = s_idle;
			default:
				state_nxt = s_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state    <= s_idle;
			idx      <= '0;
			pt_vld   <= 1'b0;
			coef_vld <= 1'b0;
			result_q <= '0;
		end
		else if (!rst_instr)
		begin
			state    <= s_idle;
			idx      <= '0;
			pt_vld   <= 1'b0;
			coef_vld <= 1'b0;
			result_q <= '0;
		end
		else
		begin
			state    <= state_nxt;
			pt_vld   <= pt_rd_en;
			coef_vld <= coef_rd_en;
			if (state == s_fetch_pt)
				idx <= N;                        // Highest coefficient first
			else if (state == s_stream && idx != '0)
				idx <= idx - 1'b1;
			if (state == s_finish)
				result_q <= fold;                // Hold between strobes
		end
	end

	// ********************
	// Datapath
	// ********************

	// One Horner step per returned coefficient
	assign fold = acc * acc_t'(x_q) + acc_t'(coef_rd_data);

	always_ff @(posedge clk)
	begin
		if (pt_vld)
			x_q <= pt_rd_data;
		if (state == s_fetch_pt)
			acc <= '0;
		else if (coef_vld)
			acc <= fold;
	end

	assign pt_rd_en     = (state == s_fetch_pt);
	assign pt_rd_addr   = point_addr;
	assign coef_rd_en   = (state == s_stream);
	assign coef_rd_addr = coef_addr_t'(A) * slot_size + coef_addr_t'(idx);

	// Last fold lands in the strobe cycle
	assign done_evp     = (state == s_finish);
	assign result_valid = (state == s_finish);
	assign result       = (state == s_finish) ? fold : result_q;

endmodule

`default_nettype wire

//--- hw/point_coef_buffer.sv
// Point and coefficient memory
`timescale 1ns/1ps
`default_nettype none

module point_coef_buffer
	import evb_pkg::*;
#(
	parameter int buffer_size = 1024,
	localparam int pt_aw = $clog2(buffer_size),
	localparam int wr_aw = (pt_aw > $bits(coef_addr_t)) ? pt_aw : $bits(coef_addr_t)
)
(
	input  wire              clk,
	input  wire              rst,
	input  wire              wr_en,
	input  wire              wr_sel,        // 0 point memory, 1 coefficient table
	input  wire  [wr_aw-1:0] wr_addr,
	input  wire  data_t      wr_data,
	input  wire              pt_rd_en,
	input  wire  [pt_aw-1:0] pt_rd_addr,
	input  wire              coef_rd_en,
	input  wire  coef_addr_t coef_rd_addr,
	output data_t            pt_rd_data,
	output data_t            coef_rd_data
);

	data_t pt_mem [buffer_size];
	data_t coef_mem [COEF_DEPTH];

	// ********************
	// Host write port
	// ********************

	always_ff @(posedge clk)
	begin
		if (wr_en && !wr_sel)
			pt_mem[wr_addr[pt_aw-1:0]] <= wr_data;
		if (wr_en && wr_sel)
			coef_mem[coef_addr_t'(wr_addr)] <= wr_data;
	end

	// Two independent read ports, data one cycle after the enable
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			pt_rd_data   <= '0;
			coef_rd_data <= '0;
		end
		else
		begin
			if (pt_rd_en)
				pt_rd_data <= pt_mem[pt_rd_addr];
			if (coef_rd_en)
				coef_rd_data <= coef_mem[coef_rd_addr];
		end
	end

endmodule

`default_nettype wire

//--- hw/evb_pkg.sv
// Batch evaluation shared types
`default_nettype none

package evb_pkg;

	// ********************
	// Value widths
	// ********************

	typedef logic [15:0] data_t;      // Point or coefficient
	typedef logic [31:0] acc_t;       // Accumulator, wraps mod 2^32
	typedef logic [2:0]  poly_sel_t;  // Polynomial select A
	typedef logic [3:0]  degree_t;    // Degree N, 0 to 15
	typedef logic [4:0]  batch_t;     // Batch count and point index

	// ********************
	// Coefficient table
	// ********************

	localparam int POLY_COEFS = 16;                     // Slots per polynomial
	localparam int POLY_NUM   = 2 ** $bits(poly_sel_t);
	localparam int COEF_DEPTH = POLY_NUM * POLY_COEFS;

	// Slot A starts at A*16, coefficient index in the low bits
	typedef logic [$clog2(COEF_DEPTH)-1:0] coef_addr_t;

endpackage

`default_nettype wire
